/* hdl/list_pkg.sv */
// Hit list package
// Sizes, enums and packed port structs shared by the hit list blocks
`default_nettype none

package list_pkg;

  localparam int NUM_RAYS    = 16;  // Rays in flight
  localparam int RAY_ID_W    = 4;   // log2 of NUM_RAYS
  localparam int DIST_W      = 16;  // Unsigned fixed point distance
  localparam int QUEUE_DEPTH = 4;   // Verdict FIFO entries

  typedef logic [RAY_ID_W-1:0] ray_id_t;
  typedef logic [DIST_W-1:0]   dist_t;
  typedef logic [7:0]          tri_id_t;

  typedef struct packed {
    logic [7:0] u;
    logic [7:0] v;
  } bary_uv_t;

  localparam dist_t DIST_MAX = '1;  // Distance of an empty record

  typedef enum logic {VERDICT_MISS, VERDICT_HIT} verdict_e;
  typedef enum logic {GRANT_TRAV0, GRANT_TRAV1} grant_e;  // Round-robin pointer

  // ------------------------------------------------
  // Port and storage structs
  // ------------------------------------------------
  typedef struct packed {
    ray_id_t ray_id;
    dist_t   t_max_leaf;  // Far bound of the leaf just entered
  } trav_to_list_t;

  typedef struct packed {
    ray_id_t  ray_id;
    logic     hit;
    dist_t    t_int;
    tri_id_t  tri_id;
    bary_uv_t uv;
    logic     is_last;  // Last triangle of the leaf
  } int_to_list_t;

  typedef struct packed {
    logic     hit;
    dist_t    t_best;
    tri_id_t  tri_id;
    bary_uv_t uv;
  } hit_record_t;

  localparam hit_record_t REC_EMPTY = '{hit: 1'b0, t_best: DIST_MAX, tri_id: '0, uv: '0};

  typedef struct packed {
    verdict_e kind;
    ray_id_t  ray_id;
    dist_t    t;       // Hit distance, or leaf bound on a miss
    tri_id_t  tri_id;
    bary_uv_t uv;
  } verdict_t;

  typedef struct packed {
    ray_id_t  ray_id;
    dist_t    t_int;
    tri_id_t  tri_id;
    bary_uv_t uv;
  } list_to_rs_t;

  typedef struct packed {
    ray_id_t ray_id;
    dist_t   t_max_leaf;
  } list_to_ss_t;

endpackage

`default_nettype wire

/* hdl/leaf_bound_store.sv */
// Leaf bound store
// Per-ray far bound registers, written by two traversal units
// Read port has priority, round-robin between traversal ports on contention
`default_nettype none

module leaf_bound_store import list_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          trav0_valid,
  input  trav_to_list_t trav0_data,
  output logic          trav0_stall,
  input  logic          trav1_valid,
  input  trav_to_list_t trav1_data,
  output logic          trav1_stall,
  input  logic          rd_en,
  input  ray_id_t       rd_ray,
  output dist_t         rd_bound
);

  dist_t         bounds [NUM_RAYS];
  grant_e        grant;       // Winner of the next contention
  logic          contend;     // Read plus both traversal writes
  logic          a_wr_en;
  logic          b_sel_trav0; // Port B carries trav0 while the read owns port A
  logic          b_wr_en;
  trav_to_list_t b_wr;

  // ------------------------------------------------
  // Port steering
  // ------------------------------------------------
  assign contend     = rd_en & trav0_valid & trav1_valid;
  assign a_wr_en     = trav0_valid & ~rd_en;  // Port A free only without a read
  assign b_sel_trav0 = rd_en & trav0_valid & (~trav1_valid | (grant == GRANT_TRAV0));
  assign b_wr_en     = b_sel_trav0 | trav1_valid;
  assign b_wr        = b_sel_trav0 ? trav0_data : trav1_data;

  // Loser of the contention waits
  assign trav0_stall = contend & (grant == GRANT_TRAV1);
  assign trav1_stall = contend & (grant == GRANT_TRAV0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant <= GRANT_TRAV0;
    end else if (contend) begin
      grant <= (grant == GRANT_TRAV0) ? GRANT_TRAV1 : GRANT_TRAV0;  // Flip per contention
    end
  end

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_RAYS; i++) begin
        bounds[i] <= DIST_MAX;
      end
    end else begin
      if (a_wr_en) bounds[trav0_data.ray_id] <= trav0_data.t_max_leaf;
      if (b_wr_en) bounds[b_wr.ray_id] <= b_wr.t_max_leaf;  // B lands last on same ray
    end
  end

  // Read data one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rd_en) rd_bound <= bounds[rd_ray];
  end

endmodule

`default_nettype wire

/* hdl/hit_record_store.sv */
// Hit record store
// Closest hit found so far for each ray, registered read and one write port
`default_nettype none

module hit_record_store import list_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Read port
  input  ray_id_t     rd_ray,
  output hit_record_t rd_record,
  // Write port
  input  logic        wr_en,
  input  ray_id_t     wr_ray,
  input  hit_record_t wr_record
);

  hit_record_t records [NUM_RAYS];

  // ------------------------------------------------
  // Record registers
  // ------------------------------------------------
  // Every ray starts empty, no hit at max distance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_RAYS; i++) begin
        records[i] <= REC_EMPTY;
      end
    end else if (wr_en) begin
      records[wr_ray] <= wr_record;  // Lands at the edge
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------
  // Sampled every cycle, so data follows the address by one clock.
  // A write at the same edge is not seen here, the control forwards it.
  always_ff @(posedge clk) begin
    rd_record <= records[rd_ray];
  end

endmodule

`default_nettype wire

/* hdl/list_ctrl.sv */
// Hit list control
// Two-stage verdict pipeline: issue reads, then pick the closest hit,
// compare against the leaf bound, update the record and push verdicts
`default_nettype none

module list_ctrl import list_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         int_valid,
  input  int_to_list_t int_data,
  output logic         int_stall,
  output logic         bound_rd_en,
  output ray_id_t      bound_rd_ray,
  input  dist_t        bound,
  output ray_id_t      rec_rd_ray,
  input  hit_record_t  rec,
  output logic         rec_wr_en,
  output ray_id_t      rec_wr_ray,
  output hit_record_t  rec_wr,
  output logic         push,
  output verdict_t     push_verdict,
  input  logic         almost_full
);

  logic         accept;
  logic         s2_valid;
  int_to_list_t s2_item;   // Item waiting for its read data
  logic         fwd_valid; // Write at the edge the current reads were sampled
  ray_id_t      fwd_ray;
  hit_record_t  fwd_rec;
  hit_record_t  cur;       // Record after forwarding
  hit_record_t  new_best;
  logic         take_new;
  logic         hit_verdict;

  // ------------------------------------------------
  // Stage 1, accept and issue reads
  // ------------------------------------------------
  assign int_stall    = almost_full;  // Room kept for stage 2 plus this item
  assign accept       = int_valid & ~int_stall;
  assign rec_rd_ray   = int_data.ray_id;
  assign bound_rd_en  = accept & int_data.is_last;  // Bound only needed at leaf end
  assign bound_rd_ray = int_data.ray_id;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid  <= 1'b0;
      fwd_valid <= 1'b0;
    end else begin
      s2_valid  <= accept;
      fwd_valid <= rec_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) s2_item <= int_data;
    fwd_ray <= rec_wr_ray;
    fwd_rec <= rec_wr;
  end

  // ------------------------------------------------
  // Stage 2, closest hit and bound compare
  // ------------------------------------------------
  always_comb begin
    cur      = (fwd_valid && fwd_ray == s2_item.ray_id) ? fwd_rec : rec;
    take_new = s2_item.hit & (~cur.hit | (s2_item.t_int <= cur.t_best));  // Tie keeps later
    new_best = cur;
    if (take_new) begin
      new_best.hit    = 1'b1;
      new_best.t_best = s2_item.t_int;
      new_best.tri_id = s2_item.tri_id;
      new_best.uv     = s2_item.uv;
    end
    hit_verdict = s2_item.is_last & new_best.hit & (new_best.t_best <= bound);

    rec_wr_en  = s2_valid;                          // Unchanged records written too
    rec_wr_ray = s2_item.ray_id;
    rec_wr     = hit_verdict ? REC_EMPTY : new_best; // Cleared once shaded

    push                = s2_valid & s2_item.is_last;
    push_verdict.kind   = hit_verdict ? VERDICT_HIT : VERDICT_MISS;
    push_verdict.ray_id = s2_item.ray_id;
    push_verdict.t      = hit_verdict ? new_best.t_best : bound;  // Miss carries bound
    push_verdict.tri_id = hit_verdict ? new_best.tri_id : '0;
    push_verdict.uv     = hit_verdict ? new_best.uv : '0;
  end

endmodule

`default_nettype wire

/* hdl/verdict_queue.sv */
// Verdict queue
// Four-entry FIFO of verdicts, head steered to shader on hit
// and to scheduler on miss
`default_nettype none

module verdict_queue import list_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push,
  input  verdict_t    push_verdict,
  output logic        almost_full,
  output logic        rs_valid,
  output list_to_rs_t rs_data,
  input  logic        rs_stall,
  output logic        ss_valid,
  output list_to_ss_t ss_data,
  input  logic        ss_stall
);

  verdict_t                       entries [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [$clog2(QUEUE_DEPTH):0]   count;
  verdict_t                       head;
  logic                           pop;

  assign head        = entries[rd_ptr];
  assign almost_full = (count >= QUEUE_DEPTH - 2);  // Two or fewer free

  // ------------------------------------------------
  // Head steering
  // ------------------------------------------------
  assign rs_valid = (count != 0) & (head.kind == VERDICT_HIT);
  assign ss_valid = (count != 0) & (head.kind == VERDICT_MISS);
  assign pop      = (rs_valid & ~rs_stall) | (ss_valid & ~ss_stall);  // Stalled head blocks all

  always_comb begin
    rs_data.ray_id    = head.ray_id;
    rs_data.t_int     = head.t;
    rs_data.tri_id    = head.tri_id;
    rs_data.uv        = head.uv;
    ss_data.ray_id    = head.ray_id;
    ss_data.t_max_leaf = head.t;  // Bound of the missed leaf
  end

  // ------------------------------------------------
  // Ring pointers
  // ------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + push - pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) entries[wr_ptr] <= push_verdict;
  end

endmodule

`default_nettype wire

/* hdl/list_unit.sv */
// Hit list top level
// Keeps the closest hit per ray and issues a hit or miss verdict
// at the end of every leaf
`default_nettype none

module list_unit import list_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  // Traversal ports
  input  logic          trav0_valid,
  input  trav_to_list_t trav0_data,
  output logic          trav0_stall,
  input  logic          trav1_valid,
  input  trav_to_list_t trav1_data,
  output logic          trav1_stall,
  // Intersection results
  input  logic          int_valid,
  input  int_to_list_t  int_data,
  output logic          int_stall,
  // Shader and scheduler
  output logic          rs_valid,
  output list_to_rs_t   rs_data,
  input  logic          rs_stall,
  output logic          ss_valid,
  output list_to_ss_t   ss_data,
  input  logic          ss_stall
);

  logic        bound_rd_en;
  ray_id_t     bound_rd_ray;
  dist_t       bound;
  ray_id_t     rec_rd_ray;
  hit_record_t rec;
  logic        rec_wr_en;
  ray_id_t     rec_wr_ray;
  hit_record_t rec_wr;
  logic        push;
  verdict_t    push_verdict;
  logic        almost_full;  // Queue backpressure into control

  leaf_bound_store leaf_bound_store_i (
    .clk, .rst_n,
    .trav0_valid, .trav0_data, .trav0_stall,
    .trav1_valid, .trav1_data, .trav1_stall,
    .rd_en    (bound_rd_en),
    .rd_ray   (bound_rd_ray),
    .rd_bound (bound)
  );

  hit_record_store hit_record_store_i (
    .clk, .rst_n,
    .rd_ray    (rec_rd_ray),
    .rd_record (rec),
    .wr_en     (rec_wr_en),
    .wr_ray    (rec_wr_ray),
    .wr_record (rec_wr)
  );

  list_ctrl list_ctrl_i (
    .clk, .rst_n,
    .int_valid, .int_data, .int_stall,
    .bound_rd_en, .bound_rd_ray, .bound,
    .rec_rd_ray, .rec,
    .rec_wr_en, .rec_wr_ray, .rec_wr,
    .push, .push_verdict, .almost_full
  );

  verdict_queue verdict_queue_i (
    .clk, .rst_n,
    .push, .push_verdict, .almost_full,
    .rs_valid, .rs_data, .rs_stall,
    .ss_valid, .ss_data, .ss_stall
  );

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
// Testbench clock source
// Free-running clock with a period of 8 time units
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  initial clk = 1'b0;
  always #4 clk = ~clk;  // Half period

endmodule

`default_nettype wire

/* verification/list_chk.sv */
// Hit list checker
// Handshake properties of the list ports, bound into list_unit
`default_nettype none

module list_chk import list_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        trav0_stall,
  input logic        trav1_stall,
  input logic        rs_valid,
  input list_to_rs_t rs_data,
  input logic        rs_stall,
  input logic        ss_valid,
  input list_to_ss_t ss_data,
  input logic        ss_stall
);

  int fail_count = 0;  // Polled by the testbench monitor

  // ------------------------------------------------
  // Port properties
  // ------------------------------------------------
  trav_one_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !(trav0_stall && trav1_stall))
    else begin
      fail_count++;
      $error("both traversal ports stalled in one cycle");
    end

  out_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !(rs_valid && ss_valid))
    else begin
      fail_count++;
      $error("shader and scheduler valid together");
    end

  // Stalled head must not move
  rs_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rs_valid && rs_stall |=> rs_valid && $stable(rs_data))
    else begin
      fail_count++;
      $error("shader output changed while stalled");
    end

  ss_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ss_valid && ss_stall |=> ss_valid && $stable(ss_data))
    else begin
      fail_count++;
      $error("scheduler output changed while stalled");
    end

endmodule

`default_nettype wire

/* verification/list_tb.sv */
// Hit list testbench
// Seeded random batches of leaf bounds and intersection results,
// verdicts checked against a per-ray model of bounds and best hits
`default_nettype none

module list_tb import list_pkg::*; ();

  localparam int NUM_BATCHES = 24;
  localparam int BATCH_RAYS  = 6;    // Under half the rays, so batches stay disjoint
  localparam int TIMEOUT     = 200;  // Cycles allowed per wait

  logic          clk;
  logic          rst_n;
  logic          trav0_valid;
  trav_to_list_t trav0_data;
  logic          trav0_stall;
  logic          trav1_valid;
  trav_to_list_t trav1_data;
  logic          trav1_stall;
  logic          int_valid;
  int_to_list_t  int_data;
  logic          int_stall;
  logic          rs_valid;
  list_to_rs_t   rs_data;
  logic          rs_stall;
  logic          ss_valid;
  list_to_ss_t   ss_data;
  logic          ss_stall;

  // Reference model state
  dist_t         model_bound [NUM_RAYS];
  hit_record_t   model_rec [NUM_RAYS];
  verdict_t      exp_q [$];          // Expected verdicts in acceptance order
  ray_id_t       cur_rays [BATCH_RAYS];
  ray_id_t       next_rays [BATCH_RAYS];
  dist_t         next_bounds [BATCH_RAYS];
  logic [NUM_RAYS-1:0] cur_mask;
  int            stall_pct;          // Output back-pressure rate
  int            int_stall_seen;

  tb_clk_gen tb_clk_gen_i (.clk);

  list_unit list_unit_i (.*);

  bind list_unit list_chk list_chk_i (
    .clk, .rst_n, .trav0_stall, .trav1_stall,
    .rs_valid, .rs_data, .rs_stall, .ss_valid, .ss_data, .ss_stall
  );

  // ------------------------------------------------
  // Reporting
  // ------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("ERR time=%0t %s actual=0x%0h expected=0x%0h",
                         $time, name, actual, expected));
    end
  endtask

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic void apply_item(input int_to_list_t item);
    hit_record_t rec;
    verdict_t    v;
    rec = model_rec[item.ray_id];
    if (item.hit && (!rec.hit || item.t_int <= rec.t_best)) begin  // Tie takes later item
      rec.hit    = 1'b1;
      rec.t_best = item.t_int;
      rec.tri_id = item.tri_id;
      rec.uv     = item.uv;
    end
    if (item.is_last) begin
      v.ray_id = item.ray_id;
      if (rec.hit && rec.t_best <= model_bound[item.ray_id]) begin
        v.kind   = VERDICT_HIT;
        v.t      = rec.t_best;
        v.tri_id = rec.tri_id;
        v.uv     = rec.uv;
        rec      = '{hit: 1'b0, t_best: '1, tri_id: '0, uv: '0};  // Shaded, start over
      end else begin
        v.kind   = VERDICT_MISS;
        v.t      = model_bound[item.ray_id];  // Record kept for next leaf
        v.tri_id = '0;
        v.uv     = '0;
      end
      exp_q.push_back(v);
    end
    model_rec[item.ray_id] = rec;
  endfunction

  // Random rays for the next batch, none of them in the current one
  function automatic void pick_next_rays();
    ray_id_t pool [NUM_RAYS];
    int      n;
    int      j;
    ray_id_t tmp;
    n = 0;
    for (int r = 0; r < NUM_RAYS; r++) begin
      if (!cur_mask[r]) begin
        pool[n] = ray_id_t'(r);
        n++;
      end
    end
    for (int i = 0; i < BATCH_RAYS; i++) begin
      j              = $urandom_range(i, n - 1);
      tmp            = pool[i];
      pool[i]        = pool[j];
      pool[j]        = tmp;
      next_rays[i]   = pool[i];
      next_bounds[i] = dist_t'($urandom_range(4, 36) * 32);  // Same grid as t_int
    end
  endfunction

  // ------------------------------------------------
  // Drivers
  // ------------------------------------------------
  task automatic send_item(input int_to_list_t item);
    int waited;
    waited = 0;
    int_valid <= 1'b1;
    int_data  <= item;
    @(posedge clk);
    while (int_stall) begin
      int_stall_seen++;
      waited++;
      if (waited > TIMEOUT) fail_run("intersection item never accepted");
      else @(posedge clk);
    end
    apply_item(item);  // Accepted at this edge
  endtask

  task automatic write_bound(input int port, input ray_id_t ray, input dist_t t);
    trav_to_list_t w;
    int            waited;
    w.ray_id     = ray;
    w.t_max_leaf = t;
    waited       = 0;
    if (port == 0) begin
      trav0_valid <= 1'b1;
      trav0_data  <= w;
    end else begin
      trav1_valid <= 1'b1;
      trav1_data  <= w;
    end
    @(posedge clk);
    while ((port == 0) ? trav0_stall : trav1_stall) begin
      waited++;
      if (waited > TIMEOUT) fail_run("traversal write never accepted");
      else @(posedge clk);
    end
    model_bound[ray] = t;
  endtask

  // Even slots on trav0, odd slots on trav1
  task automatic write_port_bounds(input int port);
    repeat ($urandom_range(0, 8)) @(posedge clk);  // Spread over the int stream
    for (int i = port; i < BATCH_RAYS; i += 2) begin
      write_bound(port, next_rays[i], next_bounds[i]);
    end
    if (port == 0) trav0_valid <= 1'b0;
    else trav1_valid <= 1'b0;
  endtask

  task automatic stream_batch();
    int           left [BATCH_RAYS];
    int           total;
    int           pick;
    int_to_list_t item;
    total = 0;
    pick  = 0;
    for (int i = 0; i < BATCH_RAYS; i++) begin
      left[i] = $urandom_range(1, 4);  // Triangles in this leaf
      total  += left[i];
    end
    while (total > 0) begin
      // Same ray again half the time, back-to-back forwarding
      if (left[pick] == 0 || $urandom_range(0, 1) == 0) pick = $urandom_range(0, BATCH_RAYS - 1);
      while (left[pick] == 0) pick = (pick + 1) % BATCH_RAYS;
      item.ray_id  = cur_rays[pick];
      item.hit     = 1'($urandom_range(0, 1));
      item.t_int   = dist_t'($urandom_range(0, 40) * 32);  // Coarse grid gives ties
      item.tri_id  = tri_id_t'($urandom_range(0, 255));
      item.uv      = bary_uv_t'($urandom);
      item.is_last = (left[pick] == 1);
      send_item(item);
      left[pick]--;
      total--;
      if ($urandom_range(0, 2) == 0) begin
        int_valid <= 1'b0;
        repeat ($urandom_range(1, 2)) @(posedge clk);  // Spaced items
      end
    end
    int_valid <= 1'b0;
  endtask

  task automatic wait_trav_idle();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while (quiet < 2) begin
      if (waited > TIMEOUT) fail_run("traversal ports did not go idle");
      else begin
        @(posedge clk);
        waited++;
        if (!trav0_stall && !trav1_stall) quiet++;
        else quiet = 0;
      end
    end
  endtask

  // ------------------------------------------------
  // Output monitor and back-pressure
  // ------------------------------------------------
  task automatic take_verdict(input verdict_e kind);
    verdict_t v;
    if (exp_q.size() == 0) fail_run("verdict delivered when none was expected");
    else begin
      v = exp_q.pop_front();
      check_value("verdict_kind", kind, v.kind);
      if (kind == VERDICT_HIT) begin
        check_value("rs_data.ray_id", rs_data.ray_id, v.ray_id);
        check_value("rs_data.t_int", rs_data.t_int, v.t);
        check_value("rs_data.tri_id", rs_data.tri_id, v.tri_id);
        check_value("rs_data.uv", rs_data.uv, v.uv);
      end else begin
        check_value("ss_data.ray_id", ss_data.ray_id, v.ray_id);
        check_value("ss_data.t_max_leaf", ss_data.t_max_leaf, v.t);
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (list_unit_i.list_chk_i.fail_count != 0) fail_run("list checker assertion failed");
      else begin
        if (rs_valid && !rs_stall) take_verdict(VERDICT_HIT);
        if (ss_valid && !ss_stall) take_verdict(VERDICT_MISS);
        rs_stall <= ($urandom_range(0, 99) < stall_pct);
        ss_stall <= ($urandom_range(0, 99) < stall_pct);
      end
    end
  end

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    int waited;
    void'($urandom(1));
    rst_n          = 1'b0;
    trav0_valid    = 1'b0;
    trav0_data     = '0;
    trav1_valid    = 1'b0;
    trav1_data     = '0;
    int_valid      = 1'b0;
    int_data       = '0;
    rs_stall       = 1'b0;
    ss_stall       = 1'b0;
    stall_pct      = 0;
    int_stall_seen = 0;
    cur_mask       = '0;
    for (int r = 0; r < NUM_RAYS; r++) begin
      model_bound[r] = '1;
      model_rec[r]   = '{hit: 1'b0, t_best: '1, tri_id: '0, uv: '0};
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("rs_valid", rs_valid, 1'b0);
    check_value("ss_valid", ss_valid, 1'b0);
    check_value("int_stall", int_stall, 1'b0);
    check_value("trav0_stall", trav0_stall, 1'b0);
    check_value("trav1_stall", trav1_stall, 1'b0);

    // First batch bounds, no int traffic yet
    pick_next_rays();
    fork
      write_port_bounds(0);
      write_port_bounds(1);
    join
    wait_trav_idle();

    for (int b = 0; b < NUM_BATCHES; b++) begin
      stall_pct = (b % 2 == 1) ? 75 : 25;  // Heavy back-pressure on odd batches
      cur_rays  = next_rays;
      cur_mask  = '0;
      for (int i = 0; i < BATCH_RAYS; i++) cur_mask[cur_rays[i]] = 1'b1;
      pick_next_rays();
      fork
        stream_batch();
        write_port_bounds(0);  // Next batch bounds race this batch's reads
        write_port_bounds(1);
      join
      wait_trav_idle();
    end

    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited > TIMEOUT) fail_run("expected verdicts never delivered");
      else begin
        @(posedge clk);
        waited++;
      end
    end
    repeat (4) @(posedge clk);
    check_value("rs_valid", rs_valid, 1'b0);  // Nothing duplicated behind the last one
    check_value("ss_valid", ss_valid, 1'b0);
    if (int_stall_seen == 0) fail_run("int_stall never rose under back-pressure");
    else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/list_pkg.sv
hdl/leaf_bound_store.sv
hdl/hit_record_store.sv
hdl/list_ctrl.sv
hdl/verdict_queue.sv
hdl/list_unit.sv
verification/tb_clk_gen.sv
verification/list_chk.sv
verification/list_tb.sv

/* Bender.yml */
package:
  name: list_unit

sources:
  - files:
      - hdl/list_pkg.sv
      - hdl/leaf_bound_store.sv
      - hdl/hit_record_store.sv
      - hdl/list_ctrl.sv
      - hdl/verdict_queue.sv
      - hdl/list_unit.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/list_chk.sv
      - verification/list_tb.sv
